/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lake_top
FILELIST  ?= lake.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build outputs"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

/* dv/tb_lake_top.sv */
`timescale 1ns/1ps

module tb_lake_top;
  import lake_pkg::*;

  localparam int max_seq = 64;

  logic                clk;
  logic                rst_n;
  logic                flush     = 1'b0;
  logic                cfg_en    = 1'b1;  // host owns the port from time 0
  logic                cfg_req   = 1'b0;
  logic                cfg_write = 1'b0;
  logic [addr_w-1:0]   cfg_addr  = '0;
  logic [data_w-1:0]   cfg_wdata = '0;
  logic [data_w-1:0]   data_in   = '0;
  logic [sel_w:0]      wr_dims   = 4'd2;
  logic [sel_w:0]      rd_dims   = 4'd2;
  cnt_t [num_dims-1:0] wr_ranges        = '0;
  cnt_t [num_dims-1:0] wr_addr_strides  = '0;
  cnt_t [num_dims-1:0] wr_sched_strides = '0;
  cnt_t [num_dims-1:0] rd_ranges        = '0;
  cnt_t [num_dims-1:0] rd_addr_strides  = '0;
  cnt_t [num_dims-1:0] rd_sched_strides = '0;
  cnt_t                wr_addr_start  = 16'd64;
  cnt_t                wr_sched_start = 16'd2;
  cnt_t                rd_addr_start  = 16'd0;
  cnt_t                rd_sched_start = 16'd5;
  logic [data_w-1:0]   data_out;
  logic                valid_out;
  logic                cfg_ack;
  logic [data_w-1:0]   cfg_rdata;

  logic [data_w-1:0] mem_model [256];
  logic [data_w-1:0] din_pat [256];
  logic [data_w-1:0] exp_mem [max_seq];
  int                exp_n  = 0;
  int                rd_idx = 0;
  cnt_t              cyc    = '0;  // mirror of the DUT cycle counter
  logic [31:0]       lcg_state;
  cnt_t              seq_buf [max_seq];
  int                seq_len;
  cnt_t              rd_seq [max_seq];
  cnt_t              wr_seq [max_seq];
  cnt_t              wr_cyc [max_seq];
  int                rd_len;
  int                wr_len;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  lake_top #(.data_w(data_w), .addr_w(addr_w), .num_dims(num_dims)) u_dut (
    .clk(clk), .rst_n(rst_n), .flush(flush), .cfg_en(cfg_en),
    .cfg_req(cfg_req), .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .wr_dims(wr_dims), .wr_ranges(wr_ranges),
    .wr_addr_start(wr_addr_start), .wr_addr_strides(wr_addr_strides),
    .wr_sched_start(wr_sched_start), .wr_sched_strides(wr_sched_strides),
    .rd_dims(rd_dims), .rd_ranges(rd_ranges),
    .rd_addr_start(rd_addr_start), .rd_addr_strides(rd_addr_strides),
    .rd_sched_start(rd_sched_start), .rd_sched_strides(rd_sched_strides),
    .data_in(data_in), .data_out(data_out), .valid_out(valid_out),
    .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_word(output logic [data_w-1:0] w);
    lcg_state = lcg_next(lcg_state);
    w = lcg_state[31:16];
  endtask

  // outputs are sampled mid-cycle, away from the driving edge
  reset_quiet: assert property (@(negedge clk) (!rst_n || $past(!rst_n)) |->
    (!valid_out && !cfg_ack))
    else fail_now("valid_out or cfg_ack high during or right after reset");
  ack_rise_order: assert property (@(negedge clk) disable iff (!rst_n)
    $rose(cfg_ack) |-> cfg_req)
    else fail_now("cfg_ack rose without cfg_req");
  ack_fall_order: assert property (@(negedge clk) disable iff (!rst_n)
    $fell(cfg_ack) |-> !cfg_req)
    else fail_now("cfg_ack fell while cfg_req still high");
  frozen_stream: assert property (@(negedge clk) disable iff (!rst_n)
    cfg_en |-> !valid_out)
    else fail_now("valid_out seen while cfg_en high");
  no_extra_word: assert property (@(negedge clk) disable iff (!rst_n)
    valid_out |-> rd_idx < exp_n)
    else fail_now("valid_out word beyond the end of the read schedule");
  stream_data: assert property (@(negedge clk) disable iff (!rst_n)
    (valid_out && rd_idx < exp_n) |-> data_out == exp_mem[rd_idx])
    else fail_now($sformatf("Mismatch data_out: got %h expected %h",
                            data_out, exp_mem[rd_idx]));

  always @(negedge clk) begin
    if (rst_n && valid_out) begin
      rd_idx <= rd_idx + 1;
    end
  end

  always @(posedge clk) begin
    if (flush) begin
      cyc <= '0;
    end else if (rst_n && !cfg_en) begin
      cyc <= cyc + cnt_t'(1);
    end
  end

  // data_in follows the cycle count so a write fire picks a known word
  always @(posedge clk) begin
    #1;
    data_in = din_pat[cyc[7:0]];
  end

  // walk the loop nest and list one address per fire
  task automatic build_loop_seq(input logic [sel_w:0] dims, input cnt_t [num_dims-1:0] rng,
                                input cnt_t [num_dims-1:0] stride, input cnt_t start);
    cnt_t cnt [num_dims];
    logic maxed [num_dims];
    cnt_t a;
    int   sel;
    a = start;
    seq_len = 0;
    for (int k = 0; k < num_dims; k++) begin
      cnt[k]   = '0;
      maxed[k] = 1'b0;
    end
    while (seq_len < max_seq) begin
      seq_buf[seq_len] = a;
      seq_len++;
      sel = -1;
      for (int k = num_dims - 1; k >= 0; k--) begin
        if (k < int'(dims) && !maxed[k] && rng[k] != '0) sel = k;
      end
      if (sel < 0) break;
      cnt[sel]   = cnt[sel] + cnt_t'(1);
      maxed[sel] = (cnt[sel] == rng[sel]);
      for (int k = 0; k < sel; k++) begin
        cnt[k]   = '0;
        maxed[k] = 1'b0;
      end
      a = a + stride[sel];
    end
  endtask

  // one four-phase config access with latency checks
  task automatic cfg_xfer(input logic wr, input logic [addr_w-1:0] a,
                          input logic [data_w-1:0] d, output logic [data_w-1:0] rd);
    int cycles;
    int lat;
    lat = wr ? 2 : 3;
    @(posedge clk);
    #1;
    cfg_write = wr;
    cfg_addr  = a;
    cfg_wdata = d;
    cfg_req   = 1'b1;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (cfg_ack) break;
      if (cycles > 20) fail_now("timeout waiting for cfg_ack to rise");
    end
    assert (cycles == lat)
      else fail_now($sformatf("Mismatch cfg_ack latency: got %h expected %h", cycles, lat));
    rd = cfg_rdata;
    @(posedge clk);
    #1;
    cfg_req = 1'b0;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (!cfg_ack) break;
      if (cycles > 20) fail_now("timeout waiting for cfg_ack to fall");
    end
    assert (cycles == 1)
      else fail_now($sformatf("Mismatch cfg_ack fall latency: got %h expected %h", cycles, 1));
  endtask

  task automatic wait_words(input int target);
    int n;
    n = 0;
    while (rd_idx < target) begin
      @(posedge clk);
      n++;
      if (n > 200) fail_now("timeout waiting for valid_out words");
    end
  endtask

  initial begin
    int               n;
    logic [data_w-1:0] w;
    logic [data_w-1:0] rd;
    int               base;
    cnt_t             cut;
    rd_ranges[0]        = 16'd3;
    rd_ranges[1]        = 16'd1;
    rd_addr_strides[0]  = 16'd1;
    rd_addr_strides[1]  = 16'd5;
    rd_sched_strides[0] = 16'd1;
    rd_sched_strides[1] = 16'd1;
    wr_ranges[0]        = 16'd3;
    wr_ranges[1]        = 16'd1;
    wr_addr_strides[0]  = 16'd1;
    wr_addr_strides[1]  = 16'd4;
    wr_sched_strides[0] = 16'd2;
    wr_sched_strides[1] = 16'd2;
    lcg_state = 32'd57163;
    for (int i = 0; i < 256; i++) begin
      next_word(din_pat[i]);
      mem_model[i] = '0;
    end

    n = 0;
    while (!rst_n) begin
      @(posedge clk);
      n++;
      if (n > 50) fail_now("reset never released");
    end

    for (int i = 0; i < 32; i++) begin
      next_word(w);
      cfg_xfer(1'b1, addr_w'(i), w, rd);
      mem_model[i] = w;
    end
    for (int i = 0; i < 32; i++) begin
      cfg_xfer(1'b0, addr_w'(i), '0, rd);
      assert (rd == mem_model[i])
        else fail_now($sformatf("Mismatch cfg_rdata: got %h expected %h", rd, mem_model[i]));
    end

    build_loop_seq(rd_dims, rd_ranges, rd_addr_strides, rd_addr_start);
    rd_len = seq_len;
    for (int k = 0; k < seq_len; k++) rd_seq[k] = seq_buf[k];
    assert (rd_len == 8) else fail_now("read schedule model does not give 8 words");
    for (int k = 0; k < rd_len; k++) begin
      exp_mem[exp_n] = mem_model[rd_seq[k][7:0]];
      exp_n++;
    end
    build_loop_seq(wr_dims, wr_ranges, wr_sched_strides, wr_sched_start);
    for (int k = 0; k < seq_len; k++) wr_cyc[k] = seq_buf[k];
    build_loop_seq(wr_dims, wr_ranges, wr_addr_strides, wr_addr_start);
    wr_len = seq_len;
    for (int k = 0; k < seq_len; k++) begin
      wr_seq[k] = seq_buf[k];
      mem_model[wr_seq[k][7:0]] = din_pat[wr_cyc[k][7:0]];
    end

    // stream with a freeze in the middle
    @(posedge clk);
    #1;
    cfg_en = 1'b0;
    wait_words(3);
    @(posedge clk);
    #1;
    cfg_en = 1'b1;
    // host read while frozen moves the memory read register
    cfg_xfer(1'b0, addr_w'(31), '0, rd);
    assert (rd == mem_model[31])
      else fail_now($sformatf("Mismatch cfg_rdata: got %h expected %h", rd, mem_model[31]));
    @(posedge clk);
    #1;
    cfg_en = 1'b0;
    wait_words(exp_n);
    n = 0;
    while (cyc < 16'd24) begin
      @(posedge clk);
      n++;
      if (n > 100) fail_now("timeout waiting for the write schedule to finish");
    end
    repeat (10) @(posedge clk);

    #1;
    cfg_en = 1'b1;
    for (int k = 0; k < wr_len; k++) begin
      cfg_xfer(1'b0, wr_seq[k][addr_w-1:0], '0, rd);
      assert (rd == mem_model[wr_seq[k][7:0]])
        else fail_now($sformatf("Mismatch cfg_rdata: got %h expected %h",
                                rd, mem_model[wr_seq[k][7:0]]));
    end

    // restart, reload, then flush mid-stream
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    for (int i = 0; i < 256; i++) mem_model[i] = '0;
    for (int i = 0; i < 12; i++) begin
      next_word(w);
      cfg_xfer(1'b1, addr_w'(i), w, rd);
      mem_model[i] = w;
    end
    base = exp_n;
    for (int k = 0; k < rd_len; k++) begin
      exp_mem[exp_n] = mem_model[rd_seq[k][7:0]];
      exp_n++;
    end
    @(posedge clk);
    #1;
    cfg_en = 1'b0;
    wait_words(base + 3);
    @(posedge clk);
    #1;
    flush = 1'b1;
    cut = cyc;  // cycle count of the flush cycle
    @(posedge clk);
    #1;
    flush = 1'b0;
    // only reads fired before the flush cycle deliver their word
    build_loop_seq(rd_dims, rd_ranges, rd_sched_strides, rd_sched_start);
    exp_n = base;
    for (int k = 0; k < seq_len; k++) begin
      if (seq_buf[k] < cut) exp_n++;
    end
    for (int k = 0; k < rd_len; k++) begin
      exp_mem[exp_n] = '0;
      exp_n++;
    end
    wait_words(exp_n);
    repeat (20) @(posedge clk);

    $display("All checks passed");
    $finish;
  end

endmodule

/* lake.f */
verilog/lake_pkg.sv
verilog/loop_iter.sv
verilog/addr_gen.sv
verilog/sched_gen.sv
verilog/strg_ub.sv
verilog/register_file.sv
verilog/cfg_seq.sv
verilog/lake_top.sv
dv/tb_clk_gen.sv
dv/tb_lake_top.sv

/* verilog/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen #(
  parameter int num_dims = lake_pkg::num_dims
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          hold,
  input  logic                          step,
  input  logic [lake_pkg::sel_w-1:0]    level_sel,
  input  lake_pkg::cnt_t                start,
  input  lake_pkg::cnt_t [num_dims-1:0] strides,
  output lake_pkg::cnt_t                addr
);
  import lake_pkg::*;

  cnt_t offset;

  assign addr = start + offset;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (flush) begin
      offset <= '0;
    end else if (!hold && step) begin
      offset <= offset + strides[level_sel];  // stride of the stepping level
    end
  end

endmodule

/* verilog/cfg_seq.sv */
`timescale 1ns/1ps

module cfg_seq #(
  parameter int data_w = lake_pkg::data_w,
  parameter int addr_w = lake_pkg::addr_w
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cfg_en,
  input  logic              cfg_req,
  input  logic              cfg_write,
  input  logic [addr_w-1:0] cfg_addr,
  input  logic [data_w-1:0] cfg_wdata,
  input  logic [data_w-1:0] mem_rdata,
  output logic              cfg_ack,
  output logic [data_w-1:0] cfg_rdata,
  output logic              mem_wen,
  output logic              mem_ren,
  output logic [addr_w-1:0] mem_addr,
  output logic [data_w-1:0] mem_wdata
);
  import lake_pkg::*;

  cfg_state_e state;
  logic       rd_pend;  // read word still in the memory read register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= cfg_idle;
      rd_pend <= 1'b0;
    end else begin
      case (state)
        cfg_idle: begin
          if (cfg_en && cfg_req) begin
            state <= cfg_access;
          end
        end
        cfg_access: begin
          state   <= cfg_done;
          rd_pend <= !cfg_write;
        end
        cfg_done: begin
          if (rd_pend) begin
            rd_pend <= 1'b0;
          end else if (!cfg_req) begin
            state <= cfg_idle;
          end
        end
        default: state <= cfg_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cfg_done && rd_pend) begin
      cfg_rdata <= mem_rdata;
    end
  end

  assign cfg_ack   = (state == cfg_done) && !rd_pend;
  assign mem_wen   = (state == cfg_access) && cfg_write;
  assign mem_ren   = (state == cfg_access) && !cfg_write;
  assign mem_addr  = cfg_addr;
  assign mem_wdata = cfg_wdata;

  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(cfg_ack) |-> cfg_req
  );

  // host keeps ownership of the memory port for the whole handshake
  en_held_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) (state != cfg_idle) |-> cfg_en
  );

endmodule

/* verilog/lake_pkg.sv */
package lake_pkg;

  parameter int data_w   = 16;
  parameter int addr_w   = 8;   // 256 words
  parameter int num_dims = 6;
  parameter int cnt_w    = 16;
  parameter int sel_w    = 3;

  // counters, ranges, strides and generated addresses
  typedef logic [cnt_w-1:0] cnt_t;

  typedef enum logic [1:0] {
    cfg_idle,
    cfg_access,
    cfg_done
  } cfg_state_e;

endpackage

/* verilog/lake_top.sv */
`timescale 1ns/1ps

module lake_top #(
  parameter int data_w   = lake_pkg::data_w,
  parameter int addr_w   = lake_pkg::addr_w,
  parameter int num_dims = lake_pkg::num_dims
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          cfg_en,
  input  logic                          cfg_req,
  input  logic                          cfg_write,
  input  logic [addr_w-1:0]             cfg_addr,
  input  logic [data_w-1:0]             cfg_wdata,
  input  logic [lake_pkg::sel_w:0]      wr_dims,
  input  lake_pkg::cnt_t [num_dims-1:0] wr_ranges,
  input  lake_pkg::cnt_t                wr_addr_start,
  input  lake_pkg::cnt_t [num_dims-1:0] wr_addr_strides,
  input  lake_pkg::cnt_t                wr_sched_start,
  input  lake_pkg::cnt_t [num_dims-1:0] wr_sched_strides,
  input  logic [lake_pkg::sel_w:0]      rd_dims,
  input  lake_pkg::cnt_t [num_dims-1:0] rd_ranges,
  input  lake_pkg::cnt_t                rd_addr_start,
  input  lake_pkg::cnt_t [num_dims-1:0] rd_addr_strides,
  input  lake_pkg::cnt_t                rd_sched_start,
  input  lake_pkg::cnt_t [num_dims-1:0] rd_sched_strides,
  input  logic [data_w-1:0]             data_in,
  output logic [data_w-1:0]             data_out,
  output logic                          valid_out,
  output logic                          cfg_ack,
  output logic [data_w-1:0]             cfg_rdata
);

  logic              ub_wen;
  logic              ub_ren;
  logic [addr_w-1:0] ub_waddr;
  logic [addr_w-1:0] ub_raddr;
  logic [data_w-1:0] ub_wdata;
  logic              cfg_wen;
  logic              cfg_ren;
  logic [addr_w-1:0] cfg_mem_addr;
  logic [data_w-1:0] cfg_mem_wdata;
  logic              rf_wen;
  logic              rf_ren;
  logic [addr_w-1:0] rf_waddr;
  logic [addr_w-1:0] rf_raddr;
  logic [data_w-1:0] rf_wdata;
  logic [data_w-1:0] rf_rdata;

  // host owns the memory port while cfg_en is high
  assign rf_wen   = cfg_en ? cfg_wen       : ub_wen;
  assign rf_ren   = cfg_en ? cfg_ren       : ub_ren;
  assign rf_waddr = cfg_en ? cfg_mem_addr  : ub_waddr;
  assign rf_raddr = cfg_en ? cfg_mem_addr  : ub_raddr;
  assign rf_wdata = cfg_en ? cfg_mem_wdata : ub_wdata;

  strg_ub #(
    .data_w(data_w), .addr_w(addr_w), .num_dims(num_dims)
  ) u_strg_ub (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(cfg_en),
    .wr_dims(wr_dims), .wr_ranges(wr_ranges),
    .wr_addr_start(wr_addr_start), .wr_addr_strides(wr_addr_strides),
    .wr_sched_start(wr_sched_start), .wr_sched_strides(wr_sched_strides),
    .rd_dims(rd_dims), .rd_ranges(rd_ranges),
    .rd_addr_start(rd_addr_start), .rd_addr_strides(rd_addr_strides),
    .rd_sched_start(rd_sched_start), .rd_sched_strides(rd_sched_strides),
    .data_in(data_in), .mem_rdata(rf_rdata),
    .mem_wen(ub_wen), .mem_ren(ub_ren),
    .mem_waddr(ub_waddr), .mem_raddr(ub_raddr), .mem_wdata(ub_wdata),
    .data_out(data_out), .valid_out(valid_out)
  );

  cfg_seq #(
    .data_w(data_w), .addr_w(addr_w)
  ) u_cfg_seq (
    .clk(clk), .rst_n(rst_n), .cfg_en(cfg_en),
    .cfg_req(cfg_req), .cfg_write(cfg_write),
    .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .mem_rdata(rf_rdata),
    .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
    .mem_wen(cfg_wen), .mem_ren(cfg_ren),
    .mem_addr(cfg_mem_addr), .mem_wdata(cfg_mem_wdata)
  );

  register_file #(
    .data_w(data_w), .addr_w(addr_w)
  ) u_rf (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata),
    .ren(rf_ren), .raddr(rf_raddr), .rdata(rf_rdata)
  );

endmodule

/* verilog/loop_iter.sv */
`timescale 1ns/1ps

module loop_iter #(
  parameter int num_dims = lake_pkg::num_dims
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          hold,
  input  logic                          step,
  input  logic [lake_pkg::sel_w:0]      dims,
  input  lake_pkg::cnt_t [num_dims-1:0] ranges,
  output logic [lake_pkg::sel_w-1:0]    level_sel,
  output logic                          done
);
  import lake_pkg::*;

  cnt_t [num_dims-1:0] cnt;
  logic [num_dims-1:0] maxed;
  cnt_t                next_cnt;
  logic                last_iter;  // every used level sits at its last value

  // lowest used level that can still count
  always_comb begin
    level_sel = '0;
    last_iter = 1'b1;
    for (int k = num_dims - 1; k >= 0; k--) begin
      if (k < int'(dims) && !(maxed[k] || ranges[k] == '0)) begin
        level_sel = sel_w'(k);
        last_iter = 1'b0;
      end
    end
  end

  assign next_cnt = cnt[level_sel] + cnt_t'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      maxed <= '0;
      done  <= 1'b0;
    end else if (flush) begin
      cnt   <= '0;
      maxed <= '0;
      done  <= 1'b0;
    end else if (!hold && step) begin
      if (last_iter) begin
        done <= 1'b1;
      end else begin
        for (int k = 0; k < num_dims; k++) begin
          if (k < int'(level_sel)) begin
            cnt[k]   <= '0;
            maxed[k] <= 1'b0;
          end else if (k == int'(level_sel)) begin
            cnt[k]   <= next_cnt;
            maxed[k] <= (next_cnt == ranges[k]);
          end
        end
      end
    end
  end

  // the schedule must stop once the loop nest is exhausted
  step_after_done: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> !step
  );

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file #(
  parameter int data_w = lake_pkg::data_w,
  parameter int addr_w = lake_pkg::addr_w
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              wen,
  input  logic [addr_w-1:0] waddr,
  input  logic [data_w-1:0] wdata,
  input  logic              ren,
  input  logic [addr_w-1:0] raddr,
  output logic [data_w-1:0] rdata
);

  logic [data_w-1:0] mem [2**addr_w];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**addr_w; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (flush) begin
      for (int i = 0; i < 2**addr_w; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else begin
      if (wen) begin
        mem[waddr] <= wdata;
      end
      if (ren) begin
        rdata <= mem[raddr];  // old word on a same-address write
      end
    end
  end

endmodule

/* verilog/sched_gen.sv */
`timescale 1ns/1ps

module sched_gen #(
  parameter int num_dims = lake_pkg::num_dims
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          hold,
  input  lake_pkg::cnt_t                cycle_count,
  input  logic [lake_pkg::sel_w-1:0]    level_sel,
  input  logic                          done,
  input  lake_pkg::cnt_t                start,
  input  lake_pkg::cnt_t [num_dims-1:0] strides,
  output logic                          fire
);
  import lake_pkg::*;

  cnt_t sched_addr;

  assign fire = (cycle_count == sched_addr) && !done;

  // next fire cycle moves on by the stride of the stepping level
  addr_gen #(
    .num_dims(num_dims)
  ) u_sched_addr (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .step(fire),
    .level_sel(level_sel),
    .start(start),
    .strides(strides),
    .addr(sched_addr)
  );

endmodule

/* verilog/strg_ub.sv */
`timescale 1ns/1ps

module strg_ub #(
  parameter int data_w   = lake_pkg::data_w,
  parameter int addr_w   = lake_pkg::addr_w,
  parameter int num_dims = lake_pkg::num_dims
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          hold,
  input  logic [lake_pkg::sel_w:0]      wr_dims,
  input  lake_pkg::cnt_t [num_dims-1:0] wr_ranges,
  input  lake_pkg::cnt_t                wr_addr_start,
  input  lake_pkg::cnt_t [num_dims-1:0] wr_addr_strides,
  input  lake_pkg::cnt_t                wr_sched_start,
  input  lake_pkg::cnt_t [num_dims-1:0] wr_sched_strides,
  input  logic [lake_pkg::sel_w:0]      rd_dims,
  input  lake_pkg::cnt_t [num_dims-1:0] rd_ranges,
  input  lake_pkg::cnt_t                rd_addr_start,
  input  lake_pkg::cnt_t [num_dims-1:0] rd_addr_strides,
  input  lake_pkg::cnt_t                rd_sched_start,
  input  lake_pkg::cnt_t [num_dims-1:0] rd_sched_strides,
  input  logic [data_w-1:0]             data_in,
  input  logic [data_w-1:0]             mem_rdata,
  output logic                          mem_wen,
  output logic                          mem_ren,
  output logic [addr_w-1:0]             mem_waddr,
  output logic [addr_w-1:0]             mem_raddr,
  output logic [data_w-1:0]             mem_wdata,
  output logic [data_w-1:0]             data_out,
  output logic                          valid_out
);
  import lake_pkg::*;

  cnt_t              cycle_count;
  logic              wr_fire;
  logic              rd_fire;
  logic [sel_w-1:0]  wr_sel;
  logic [sel_w-1:0]  rd_sel;
  logic              wr_done;
  logic              rd_done;
  cnt_t              wr_gen_addr;
  cnt_t              rd_gen_addr;
  logic              valid_q;
  logic              hold_q;
  logic [data_w-1:0] parked_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_count <= '0;
      valid_q     <= 1'b0;
      hold_q      <= 1'b0;
    end else begin
      hold_q <= hold;
      if (flush) begin
        cycle_count <= '0;
        valid_q     <= 1'b0;
      end else if (!hold) begin
        cycle_count <= cycle_count + cnt_t'(1);
        valid_q     <= rd_fire;  // registered read lands next cycle
      end
    end
  end

  // config reads may overwrite the read register while the host owns the port
  always_ff @(posedge clk) begin
    if (hold && !hold_q) begin
      parked_data <= mem_rdata;
    end
  end

  assign data_out  = hold_q ? parked_data : mem_rdata;
  assign valid_out = valid_q && !hold;

  assign mem_wen   = wr_fire;
  assign mem_ren   = rd_fire;
  assign mem_waddr = wr_gen_addr[addr_w-1:0];
  assign mem_raddr = rd_gen_addr[addr_w-1:0];
  assign mem_wdata = data_in;

  loop_iter #(.num_dims(num_dims)) u_wr_loop (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .step(wr_fire), .dims(wr_dims), .ranges(wr_ranges),
    .level_sel(wr_sel), .done(wr_done)
  );

  addr_gen #(.num_dims(num_dims)) u_wr_addr (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .step(wr_fire), .level_sel(wr_sel),
    .start(wr_addr_start), .strides(wr_addr_strides), .addr(wr_gen_addr)
  );

  sched_gen #(.num_dims(num_dims)) u_wr_sched (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .cycle_count(cycle_count), .level_sel(wr_sel), .done(wr_done),
    .start(wr_sched_start), .strides(wr_sched_strides), .fire(wr_fire)
  );

  loop_iter #(.num_dims(num_dims)) u_rd_loop (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .step(rd_fire), .dims(rd_dims), .ranges(rd_ranges),
    .level_sel(rd_sel), .done(rd_done)
  );

  addr_gen #(.num_dims(num_dims)) u_rd_addr (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .step(rd_fire), .level_sel(rd_sel),
    .start(rd_addr_start), .strides(rd_addr_strides), .addr(rd_gen_addr)
  );

  sched_gen #(.num_dims(num_dims)) u_rd_sched (
    .clk(clk), .rst_n(rst_n), .flush(flush), .hold(hold),
    .cycle_count(cycle_count), .level_sel(rd_sel), .done(rd_done),
    .start(rd_sched_start), .strides(rd_sched_strides), .fire(rd_fire)
  );

endmodule
